// File: tb.f
+incdir+common
common/pkt_pkg.sv
src/tx_ram.sv
src/adc_fifo_bank.sv
packet/pkt_ctrl.sv
packet/pkt_byte_fmt.sv
src/pkt_top.sv
testbench/pkt_asserts.sv
testbench/tb_pkt.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt -f tb.f -o sim_pkt

./obj_dir/sim_pkt 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without a failure report"

// File: testbench/tb_pkt.sv
`timescale 1ns/10ps
`include "pkt_consts.svh"

module tb_pkt;

    localparam int RAM_SIZE      = 1 << `PKT_RAM_AW;
    localparam int FRAME_TIMEOUT = 2000;   // A data frame needs about 530 cycles
    localparam int NO_FD_WINDOW  = 100;

    logic        clk;
    logic        rst;
    logic        fs;
    logic        fd;
    logic [3:0]  btype;
    logic [11:0] base_addr;
    logic [31:0] data_cmd;
    logic [31:0] data_stat;
    logic [7:0]  adc_wr;
    logic [63:0] adc_wdata;
    logic [11:0] rd_addr;
    logic [7:0]  rd_data;

    logic [7:0]  ram_model [0:RAM_SIZE-1];
    logic        ram_known [0:RAM_SIZE-1];   // Written at least once
    int          value_errors;
    int          timeouts;
    int unsigned rand_seed;

    pkt_top i_pkt_top (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fd        (fd),
        .btype     (btype),
        .base_addr (base_addr),
        .data_cmd  (data_cmd),
        .data_stat (data_stat),
        .adc_wr    (adc_wr),
        .adc_wdata (adc_wdata),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic model_write(input logic [11:0] addr, input logic [7:0] value);
        ram_model[addr] = value;
        ram_known[addr] = 1'b1;
    endtask

    task automatic wait_fd(input logic level, input int limit, output logic seen);
        int n;
        n = 0;
        while (fd !== level && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        seen = (fd === level);
    endtask

    // Raise fs, wait for fd, keep fs for hold cycles, then release
    task automatic run_frame(input logic [3:0] code, input logic [11:0] base, input int hold);
        logic seen;
        @(posedge clk);
        #1;
        btype     = code;
        base_addr = base;
        fs        = 1'b1;
        wait_fd(1'b1, FRAME_TIMEOUT, seen);
        if (seen) begin
            repeat (hold) begin
                @(posedge clk);
                #1;
                if (fd !== 1'b1) begin
                    $display("[FAIL] %0t fd got %b expected 1", $time, fd);
                    value_errors++;
                end
            end
        end else begin
            $display("Timeout at %0t: fd did not rise for code %h", $time, code);
            timeouts++;
        end
        fs = 1'b0;
        wait_fd(1'b0, FRAME_TIMEOUT, seen);
        if (!seen) begin
            $display("Timeout at %0t: fd stayed high after fs fell", $time);
            timeouts++;
        end
    endtask

    task automatic check_ram(input logic [11:0] start, input int len);
        logic [11:0] addr;
        int          i;
        for (i = 0; i < len; i++) begin
            addr = start + 12'(i);
            if (ram_known[addr]) begin
                @(posedge clk);
                #1;
                rd_addr = addr;
                @(posedge clk);
                #1;
                if (rd_data !== ram_model[addr]) begin
                    $display("[FAIL] %0t rd_data at %03h got %02h expected %02h",
                             $time, addr, rd_data, ram_model[addr]);
                    value_errors++;
                end
            end
        end
    endtask

    // Lane k lands at base+2+64k in FIFO order
    task automatic fill_lanes(input logic [11:0] base);
        logic [63:0] word;
        int          j;
        int          k;
        for (j = 0; j < `PKT_CHIP_LEN; j++) begin
            word = {$urandom, $urandom};
            @(posedge clk);
            #1;
            adc_wr    = 8'hFF;
            adc_wdata = word;
            for (k = 0; k < `PKT_LANES; k++) begin
                model_write(base + 12'(2 + `PKT_CHIP_LEN * k + j), word[63 - 8*k -: 8]);
            end
        end
        @(posedge clk);
        #1;
        adc_wr = 8'h00;
    endtask

    task automatic short_frame(input logic [3:0] code, input logic [11:0] base,
                               input logic [7:0] b0, input logic [7:0] b1, input int hold);
        model_write(base, b0);
        model_write(base + 12'd1, b1);
        run_frame(code, base, hold);
        check_ram(base - 12'd1, 4);
    endtask

    task automatic randomize_fields();
        @(posedge clk);
        #1;
        data_cmd  = $urandom;
        data_stat = $urandom;
    endtask

    task automatic link_packet();
        short_frame(pkt_pkg::CODE_LINK, 12'h010, 8'hD1, 8'h23, 0);
    endtask

    task automatic type_temp_packets();
        randomize_fields();
        short_frame(pkt_pkg::CODE_TYPE, 12'h020, {4'h1, data_cmd[31:28]}, data_stat[15:8], 0);
        short_frame(pkt_pkg::CODE_TEMP, 12'h030, {4'h9, data_cmd[31:28]}, data_stat[30:23], 0);
    endtask

    task automatic data_packet(input logic [3:0] code, input logic [11:0] base);
        randomize_fields();
        fill_lanes(base);
        model_write(base, {4'h3, data_cmd[31:28]});
        model_write(base + 12'd1, {data_cmd[27:24], data_stat[7:4]});
        run_frame(code, base, 0);
        check_ram(base - 12'd1, 2 + `PKT_LANES * `PKT_CHIP_LEN + 2);
    endtask

    task automatic unknown_code(input logic [11:0] base);
        logic seen;
        @(posedge clk);
        #1;
        btype     = 4'h3;
        base_addr = base;
        fs        = 1'b1;
        wait_fd(1'b1, NO_FD_WINDOW, seen);
        if (seen) begin
            $display("[FAIL] %0t fd got 1 expected 0 for unknown code", $time);
            value_errors++;
        end
        @(posedge clk);
        #1;
        fs = 1'b0;
        wait_fd(1'b0, FRAME_TIMEOUT, seen);
        if (!seen) begin
            $display("Timeout at %0t: fd stayed high after an unknown code", $time);
            timeouts++;
        end
        check_ram(base - 12'd4, 12);
    endtask

    task automatic handshake_frames();
        randomize_fields();
        short_frame(pkt_pkg::CODE_LINK, 12'h400, 8'hD1, 8'h23, 6);
        short_frame(pkt_pkg::CODE_TYPE, 12'h404, {4'h1, data_cmd[31:28]}, data_stat[15:8], 0);
    endtask

    initial begin
        int i;
        rand_seed    = $urandom(32'h1b7);
        rst          = 1'b1;
        fs           = 1'b0;
        btype        = 4'h0;
        base_addr    = 12'h000;
        data_cmd     = 32'h0;
        data_stat    = 32'h0;
        adc_wr       = 8'h00;
        adc_wdata    = 64'h0;
        rd_addr      = 12'h000;
        value_errors = 0;
        timeouts     = 0;
        for (i = 0; i < RAM_SIZE; i++) begin
            ram_known[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        if (fd !== 1'b0 || i_pkt_top.ram_we !== 1'b0 || i_pkt_top.lane_pop !== 8'h00) begin
            $display("[FAIL] %0t fd/ram_we/lane_pop got %b/%b/%h expected 0/0/00",
                     $time, fd, i_pkt_top.ram_we, i_pkt_top.lane_pop);
            value_errors++;
        end
        link_packet();
        type_temp_packets();
        data_packet(pkt_pkg::CODE_DATA0, 12'h100);
        unknown_code(12'h140);
        data_packet(pkt_pkg::CODE_DATA1, 12'hF00);   // Wraps past FFF
        handshake_frames();
        $display("Error counts: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/pkt_asserts.sv
`timescale 1ns/10ps

module pkt_asserts (
    input logic       clk,
    input logic       rst,
    input logic       fs,
    input logic       fd,
    input logic [7:0] lane_pop,
    input logic [7:0] lane_empty
);

    pop_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(lane_pop))
        else $error("lane_pop has more than one lane set: %b", lane_pop);

    pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        (lane_pop & lane_empty) == 8'h00)
        else $error("pop of an empty lane: pop %b empty %b", lane_pop, lane_empty);

    fd_hold: assert property (@(posedge clk) disable iff (rst) fd && fs |=> fd)
        else $error("fd fell while fs was still high");

endmodule

// Control instance has no FIFO state, bank instance has no frame levels
bind pkt_ctrl pkt_asserts i_ctrl_asserts (
    .clk        (clk),
    .rst        (rst),
    .fs         (fs),
    .fd         (fd),
    .lane_pop   (lane_pop),
    .lane_empty (8'h00)
);

bind adc_fifo_bank pkt_asserts i_fifo_asserts (
    .clk        (clk),
    .rst        (rst),
    .fs         (1'b0),
    .fd         (1'b0),
    .lane_pop   (lane_pop),
    .lane_empty (lane_empty)
);

// File: src/pkt_top.sv
`timescale 1ns/10ps
`include "pkt_consts.svh"

module pkt_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fs,
    output logic                     fd,
    input  logic [3:0]               btype,
    input  logic [`PKT_RAM_AW-1:0]   base_addr,
    input  logic [31:0]              data_cmd,
    input  logic [31:0]              data_stat,
    input  logic [`PKT_LANES-1:0]    adc_wr,      // Bit 7 is lane 0
    input  logic [8*`PKT_LANES-1:0]  adc_wdata,   // Lane 0 on 63:56
    input  logic [`PKT_RAM_AW-1:0]   rd_addr,
    output logic [7:0]               rd_data
);

    pkt_pkg::pkt_code_e          btype_code;
    pkt_pkg::pkt_state_e         state;
    pkt_pkg::byte_sel_e          byte_sel;
    logic                        load_addr;
    logic [2:0]                  cnum;
    logic [`PKT_LANES-1:0]       lane_pop;
    logic [8*`PKT_LANES-1:0]     lane_head;
    logic [`PKT_RAM_AW-1:0]      ram_wa;
    logic [7:0]                  ram_wd;
    logic                        ram_we;

    assign btype_code = pkt_pkg::pkt_code_e'(btype);

    pkt_ctrl i_pkt_ctrl (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .btype     (btype_code),
        .fd        (fd),
        .state     (state),
        .byte_sel  (byte_sel),
        .load_addr (load_addr),
        .cnum      (cnum),
        .lane_pop  (lane_pop)
    );

    pkt_byte_fmt i_pkt_byte_fmt (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .byte_sel  (byte_sel),
        .load_addr (load_addr),
        .base_addr (base_addr),
        .cnum      (cnum),
        .data_cmd  (data_cmd),
        .data_stat (data_stat),
        .lane_head (lane_head),
        .ram_wa    (ram_wa),
        .ram_wd    (ram_wd),
        .ram_we    (ram_we)
    );

    adc_fifo_bank i_adc_fifo_bank (
        .clk        (clk),
        .rst        (rst),
        .adc_wr     (adc_wr),
        .adc_wdata  (adc_wdata),
        .lane_pop   (lane_pop),
        .lane_head  (lane_head),
        .lane_empty ()            // Checked by the bound assertions
    );

    tx_ram i_tx_ram (
        .clk (clk),
        .we  (ram_we),
        .wa  (ram_wa),
        .wd  (ram_wd),
        .ra  (rd_addr),
        .rd  (rd_data)
    );

endmodule

// File: packet/pkt_byte_fmt.sv
`timescale 1ns/10ps
`include "pkt_consts.svh"

module pkt_byte_fmt (
    input  logic                     clk,
    input  logic                     rst,
    input  pkt_pkg::pkt_state_e      state,
    input  pkt_pkg::byte_sel_e       byte_sel,
    input  logic                     load_addr,
    input  logic [`PKT_RAM_AW-1:0]   base_addr,
    input  logic [2:0]               cnum,
    input  logic [31:0]              data_cmd,
    input  logic [31:0]              data_stat,
    input  logic [8*`PKT_LANES-1:0]  lane_head,
    output logic [`PKT_RAM_AW-1:0]   ram_wa,
    output logic [7:0]               ram_wd,
    output logic                     ram_we
);

    localparam logic [11:0] LINK_WORD = `PKT_LINK_WORD;

    logic [`PKT_NIB_W-1:0]  dev_idx;
    logic [`PKT_NIB_W-1:0]  data_idx;
    logic [`PKT_BYTE_W-1:0] dev_temp;
    logic [`PKT_BYTE_W-1:0] dev_type;
    logic [`PKT_NIB_W-1:0]  dev_stat;
    logic [7:0]             lane_byte;
    logic [7:0]             byte_next;

    assign dev_idx  = data_cmd[`PKT_DEV_IDX_MSB -: `PKT_NIB_W];
    assign data_idx = data_cmd[`PKT_DATA_IDX_MSB -: `PKT_NIB_W];
    assign dev_temp = data_stat[`PKT_TEMP_MSB -: `PKT_BYTE_W];
    assign dev_type = data_stat[`PKT_TYPE_MSB -: `PKT_BYTE_W];
    assign dev_stat = data_stat[`PKT_STAT_MSB -: `PKT_NIB_W];

    // Chip 0 sits in the top byte
    assign lane_byte = lane_head[8*(`PKT_LANES - 1 - cnum) +: 8];

    always_comb begin
        case (byte_sel)
            pkt_pkg::SEL_LINK_HI:   byte_next = {`PKT_HEAD_LINK, LINK_WORD[11:8]};
            pkt_pkg::SEL_LINK_LO:   byte_next = LINK_WORD[7:0];
            pkt_pkg::SEL_TYPE_HEAD: byte_next = {`PKT_HEAD_TYPE, dev_idx};
            pkt_pkg::SEL_TYPE_VAL:  byte_next = dev_type;
            pkt_pkg::SEL_TEMP_HEAD: byte_next = {`PKT_HEAD_TEMP, dev_idx};
            pkt_pkg::SEL_TEMP_VAL:  byte_next = dev_temp;
            pkt_pkg::SEL_DATA_HEAD: byte_next = {`PKT_HEAD_DATA, dev_idx};
            pkt_pkg::SEL_DATA_INFO: byte_next = {data_idx, dev_stat};
            pkt_pkg::SEL_LANE:      byte_next = lane_byte;
            default:                byte_next = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        ram_wd <= byte_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_we <= 1'b0;
        end else begin
            ram_we <= (byte_sel != pkt_pkg::SEL_NONE);
        end
    end

    // Address moves with each write, holds over the gap between chips
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_wa <= `PKT_ADDR_IDLE;
        end else if (load_addr) begin
            ram_wa <= base_addr;
        end else if (byte_sel != pkt_pkg::SEL_NONE) begin
            ram_wa <= ram_wa + 12'd1;     // Wraps above FFF
        end else if (state != pkt_pkg::ST_DATA_GAP) begin
            ram_wa <= `PKT_ADDR_IDLE;
        end
    end

endmodule

// File: packet/pkt_ctrl.sv
`timescale 1ns/10ps
`include "pkt_consts.svh"

module pkt_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fs,
    input  pkt_pkg::pkt_code_e     btype,
    output logic                   fd,
    output pkt_pkg::pkt_state_e    state,
    output pkt_pkg::byte_sel_e     byte_sel,
    output logic                   load_addr,
    output logic [2:0]             cnum,
    output logic [`PKT_LANES-1:0]  lane_pop
);

    pkt_pkg::pkt_state_e state_next;
    logic [6:0]          dlen;           // Bytes of the current chip
    logic                last_byte;
    logic                last_chip;

    assign last_byte = (dlen >= 7'(`PKT_CHIP_LEN - 2));   // Leaves one for REST
    assign last_chip = (cnum == 3'(`PKT_LANES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pkt_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            pkt_pkg::ST_IDLE: state_next = pkt_pkg::ST_WAIT;
            pkt_pkg::ST_WAIT: begin
                state_next = pkt_pkg::ST_WAIT;
                if (fs) begin
                    case (btype)
                        pkt_pkg::CODE_LINK:  state_next = pkt_pkg::ST_LINK_HEAD;
                        pkt_pkg::CODE_TYPE:  state_next = pkt_pkg::ST_TYPE_HEAD;
                        pkt_pkg::CODE_TEMP:  state_next = pkt_pkg::ST_TEMP_HEAD;
                        pkt_pkg::CODE_DATA0: state_next = pkt_pkg::ST_DATA_HEAD0;
                        pkt_pkg::CODE_DATA1: state_next = pkt_pkg::ST_DATA_HEAD0;
                        default:             state_next = pkt_pkg::ST_WAIT;  // Unknown code
                    endcase
                end
            end
            pkt_pkg::ST_DONE: begin
                state_next = fs ? pkt_pkg::ST_DONE : pkt_pkg::ST_WAIT;
            end
            pkt_pkg::ST_LINK_HEAD: state_next = pkt_pkg::ST_LINK_BODY;
            pkt_pkg::ST_LINK_BODY: state_next = pkt_pkg::ST_DONE;
            pkt_pkg::ST_TYPE_HEAD: state_next = pkt_pkg::ST_TYPE_BODY;
            pkt_pkg::ST_TYPE_BODY: state_next = pkt_pkg::ST_DONE;
            pkt_pkg::ST_TEMP_HEAD: state_next = pkt_pkg::ST_TEMP_BODY;
            pkt_pkg::ST_TEMP_BODY: state_next = pkt_pkg::ST_DONE;
            pkt_pkg::ST_DATA_HEAD0: state_next = pkt_pkg::ST_DATA_HEAD1;
            pkt_pkg::ST_DATA_HEAD1: state_next = pkt_pkg::ST_DATA_GAP;
            pkt_pkg::ST_DATA_GAP:   state_next = pkt_pkg::ST_DATA_WORK;
            pkt_pkg::ST_DATA_WORK: begin
                state_next = last_byte ? pkt_pkg::ST_DATA_REST : pkt_pkg::ST_DATA_WORK;
            end
            pkt_pkg::ST_DATA_REST: begin
                state_next = last_chip ? pkt_pkg::ST_DONE : pkt_pkg::ST_DATA_GAP;
            end
            default: state_next = pkt_pkg::ST_IDLE;
        endcase
    end

    // Byte source for the write registered this cycle
    always_comb begin
        case (state)
            pkt_pkg::ST_LINK_HEAD:  byte_sel = pkt_pkg::SEL_LINK_HI;
            pkt_pkg::ST_LINK_BODY:  byte_sel = pkt_pkg::SEL_LINK_LO;
            pkt_pkg::ST_TYPE_HEAD:  byte_sel = pkt_pkg::SEL_TYPE_HEAD;
            pkt_pkg::ST_TYPE_BODY:  byte_sel = pkt_pkg::SEL_TYPE_VAL;
            pkt_pkg::ST_TEMP_HEAD:  byte_sel = pkt_pkg::SEL_TEMP_HEAD;
            pkt_pkg::ST_TEMP_BODY:  byte_sel = pkt_pkg::SEL_TEMP_VAL;
            pkt_pkg::ST_DATA_HEAD0: byte_sel = pkt_pkg::SEL_DATA_HEAD;
            pkt_pkg::ST_DATA_HEAD1: byte_sel = pkt_pkg::SEL_DATA_INFO;
            pkt_pkg::ST_DATA_WORK,
            pkt_pkg::ST_DATA_REST:  byte_sel = pkt_pkg::SEL_LANE;
            default:                byte_sel = pkt_pkg::SEL_NONE;
        endcase
    end

    assign load_addr = (state == pkt_pkg::ST_LINK_HEAD) || (state == pkt_pkg::ST_TYPE_HEAD) ||
                       (state == pkt_pkg::ST_TEMP_HEAD) || (state == pkt_pkg::ST_DATA_HEAD0);

    assign fd = (state == pkt_pkg::ST_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dlen <= 7'd0;
        end else if (state == pkt_pkg::ST_DATA_WORK) begin
            dlen <= dlen + 7'd1;
        end else begin
            dlen <= 7'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnum <= 3'd0;
        end else if (state == pkt_pkg::ST_DATA_REST) begin
            cnum <= cnum + 3'd1;    // Wraps to 0 after the last chip
        end else if (state == pkt_pkg::ST_WAIT) begin
            cnum <= 3'd0;
        end
    end

    // Pop goes out one cycle before the write that needs the next head
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_pop <= '0;
        end else if (state == pkt_pkg::ST_DATA_GAP || state == pkt_pkg::ST_DATA_WORK) begin
            lane_pop <= 8'h80 >> cnum;     // Lane 0 on bit 7
        end else begin
            lane_pop <= '0;
        end
    end

endmodule

// File: src/adc_fifo_bank.sv
`timescale 1ns/10ps
`include "pkt_consts.svh"

module adc_fifo_bank (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`PKT_LANES-1:0]    adc_wr,
    input  logic [8*`PKT_LANES-1:0]  adc_wdata,
    input  logic [`PKT_LANES-1:0]    lane_pop,
    output logic [8*`PKT_LANES-1:0]  lane_head,
    output logic [`PKT_LANES-1:0]    lane_empty
);

    localparam int AW = 7;     // 128 bytes per lane

    // Bit i of the strobes goes with byte slice i, so bit 7 is lane 0
    genvar i;
    for (i = 0; i < `PKT_LANES; i++) begin : g_lane
        logic [7:0]  mem [0:(1<<AW)-1];
        logic [AW:0] wr_ptr;
        logic [AW:0] rd_ptr;

        always_ff @(posedge clk) begin
            if (adc_wr[i]) begin
                mem[wr_ptr[AW-1:0]] <= adc_wdata[8*i +: 8];
            end
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                wr_ptr <= '0;
            end else if (adc_wr[i]) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                rd_ptr <= '0;
            end else if (lane_pop[i]) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end

        // Head shows the oldest byte without a read request
        assign lane_head[8*i +: 8] = mem[rd_ptr[AW-1:0]];
        assign lane_empty[i]       = (wr_ptr == rd_ptr);
    end

endmodule

// File: src/tx_ram.sv
`timescale 1ns/10ps
`include "pkt_consts.svh"

module tx_ram (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`PKT_RAM_AW-1:0]  wa,
    input  logic [7:0]              wd,
    input  logic [`PKT_RAM_AW-1:0]  ra,
    output logic [7:0]              rd
);

    logic [7:0] mem [0:(1<<`PKT_RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    // Host read, one cycle latency
    always_ff @(posedge clk) begin
        rd <= mem[ra];
    end

endmodule

// File: common/pkt_pkg.sv
package pkt_pkg;

    // Control FSM states, grouped by packet type
    typedef enum logic [7:0] {
        ST_IDLE       = 8'h00,
        ST_WAIT       = 8'h01,
        ST_DONE       = 8'h02,
        ST_LINK_HEAD  = 8'h10,
        ST_LINK_BODY  = 8'h11,
        ST_TYPE_HEAD  = 8'h20,
        ST_TYPE_BODY  = 8'h21,
        ST_TEMP_HEAD  = 8'h30,
        ST_TEMP_BODY  = 8'h31,
        ST_DATA_HEAD0 = 8'h40,
        ST_DATA_HEAD1 = 8'h41,
        ST_DATA_GAP   = 8'h42,
        ST_DATA_WORK  = 8'h43,
        ST_DATA_REST  = 8'h44
    } pkt_state_e;

    // Packet codes on btype
    typedef enum logic [3:0] {
        CODE_LINK  = 4'h8,
        CODE_TYPE  = 4'h9,
        CODE_TEMP  = 4'hA,
        CODE_DATA0 = 4'hD,
        CODE_DATA1 = 4'hE
    } pkt_code_e;

    // Byte source for the formatter
    typedef enum logic [3:0] {
        SEL_NONE, SEL_LINK_HI, SEL_LINK_LO, SEL_TYPE_HEAD, SEL_TYPE_VAL,
        SEL_TEMP_HEAD, SEL_TEMP_VAL, SEL_DATA_HEAD, SEL_DATA_INFO, SEL_LANE
    } byte_sel_e;

endpackage

// File: common/pkt_consts.svh
`ifndef PKT_CONSTS_SVH
`define PKT_CONSTS_SVH

// Header nibbles, upper half of the first packet byte
`define PKT_HEAD_LINK 4'hD
`define PKT_HEAD_TYPE 4'h1
`define PKT_HEAD_TEMP 4'h9
`define PKT_HEAD_DATA 4'h3

`define PKT_LINK_WORD 12'h123

// Data packet geometry
`define PKT_LANES 8
`define PKT_CHIP_LEN 64

// Transmit RAM
`define PKT_RAM_AW 12
`define PKT_ADDR_IDLE 12'hFE0

// Field MSB positions in data_cmd and data_stat
`define PKT_DEV_IDX_MSB 31
`define PKT_DATA_IDX_MSB 27
`define PKT_TEMP_MSB 30
`define PKT_TYPE_MSB 15
`define PKT_STAT_MSB 7

`define PKT_NIB_W 4
`define PKT_BYTE_W 8

`endif
